/* include/uart_macros.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uart peripheral constants
// bit time, bit counter width and APB register offsets
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// clock cycles per serial bit, fixed at build time
`define UART_CLKS_PER_BIT 16

// width of the down-counter that times one bit
// counter runs from UART_CLKS_PER_BIT-1 down to zero
`define UART_CNT_W $clog2(`UART_CLKS_PER_BIT)

// byte offsets on the 4-bit paddr
`define UART_ADDR_DATA   4'h0
`define UART_ADDR_STATUS 4'h4

`endif

/* verilog/uart_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uart peripheral types
// data byte, received frame, status word and register names
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "uart_macros.svh"

package uart_pkg;

  // one serial data byte
  typedef logic [7:0] uart_byte_t;

  // received frame as held for the CPU
  // frame_err is set when the stop bit was sampled low
  typedef struct packed {
    logic       frame_err;
    uart_byte_t data;
  } uart_rx_frame_t;

  // STATUS read value, bit 0 is tx_full
  // rx_frame_err belongs to the frame currently held
  typedef struct packed {
    logic rx_frame_err;
    logic rx_avail;
    logic tx_full;
  } uart_status_t;

  // register map on paddr
  typedef enum logic [3:0] {
    REG_DATA   = `UART_ADDR_DATA,
    REG_STATUS = `UART_ADDR_STATUS
  } uart_reg_e;

endpackage

/* verilog/hold_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// holding register link
// joins a one-entry store to its producer and consumer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

interface hold_if #(
  parameter type payload_t = uart_pkg::uart_byte_t
) ();

  // write side, wr_en only while full is low
  payload_t wr_data;
  logic     wr_en;
  logic     full;

  // read side, rd_en only while rd_valid is high
  payload_t rd_data;
  logic     rd_valid;
  logic     rd_en;

  // the one-entry store itself
  modport store (
    input  wr_data, wr_en, rd_en,
    output full, rd_data, rd_valid
  );

  modport producer (output wr_data, wr_en, input full);

  modport consumer (input rd_data, rd_valid, output rd_en);

endinterface

/* verilog/uart_hold_reg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one-entry holding register
// keeps a single payload plus valid flag between two blocks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module uart_hold_reg #(
  parameter type payload_t = uart_pkg::uart_byte_t
) (
  input  logic  clk,
  input  logic  rst_n,
  hold_if.store link
);

  payload_t data_q;
  logic     valid_q;

  // payload captured on every accepted write
  always_ff @(posedge clk) begin
    if (link.wr_en) begin
      data_q <= link.wr_data;
    end
  end

  // valid set by a write, cleared by a read
  // protocol keeps the two from meeting in one cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (link.wr_en) begin
      valid_q <= 1'b1;
    end else if (link.rd_en) begin
      valid_q <= 1'b0;
    end
  end

  assign link.full     = valid_q;
  assign link.rd_valid = valid_q;
  assign link.rd_data  = data_q;

  // producer must respect full, else the held entry is overwritten
  a_no_write_when_full : assert property (
    @(posedge clk) disable iff (!rst_n) link.wr_en |-> !valid_q
  );

  // consumer must respect rd_valid
  a_no_read_when_empty : assert property (
    @(posedge clk) disable iff (!rst_n) link.rd_en |-> valid_q
  );

endmodule

/* verilog/apb_reg_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB register decoder
// zero-wait slave for DATA and STATUS, feeds the tx holding
// register and drains the rx holding register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module apb_reg_decode (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [3:0]  paddr,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  hold_if.producer    tx,
  hold_if.consumer    rx
);

  import uart_pkg::*;

  logic         access;
  logic         wr_access;
  logic         rd_access;
  logic         is_data;
  logic         is_status;
  logic         bad_addr;
  logic         tx_refused;
  logic         rx_empty_rd;
  uart_status_t status;

  // access phase of a transfer
  assign access    = psel && penable;
  assign wr_access = access && pwrite;
  assign rd_access = access && !pwrite;

  // address decode
  assign is_data   = (paddr == REG_DATA);
  assign is_status = (paddr == REG_STATUS);
  assign bad_addr  = !is_data && !is_status;

  // no wait states
  assign pready = access;

  // DATA write pushes the low byte while tx has room
  assign tx.wr_en   = wr_access && is_data && !tx.full;
  assign tx.wr_data = pwdata[7:0];

  // DATA read pops the held frame on the edge ending the access
  assign rx.rd_en = rd_access && is_data && rx.rd_valid;

  // error cases
  // write into a full tx register loses the byte
  assign tx_refused  = wr_access && is_data && tx.full;
  // read with nothing received
  assign rx_empty_rd = rd_access && is_data && !rx.rd_valid;

  assign pslverr = tx_refused || rx_empty_rd || (access && bad_addr);

  // frame_err only means something while a frame is held
  assign status.tx_full      = tx.full;
  assign status.rx_avail     = rx.rd_valid;
  assign status.rx_frame_err = rx.rd_valid && rx.rd_data.frame_err;

  // read mux, zero whenever nothing valid is addressed
  always_comb begin
    prdata = '0;
    if (rd_access) begin
      if (is_data && rx.rd_valid) begin
        prdata[7:0] = rx.rd_data.data;
      end else if (is_status) begin
        prdata[$bits(uart_status_t)-1:0] = status;
      end
    end
  end

  // APB master must hold psel through the access phase
  a_penable_needs_psel : assert property (
    @(posedge clk) disable iff (!rst_n) penable |-> psel
  );

endmodule

/* verilog/uart_tx.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uart transmit engine
// pops bytes from the tx holding register, sends 8N1 on txd
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "uart_macros.svh"

module uart_tx (
  input  logic     clk,
  input  logic     rst_n,
  hold_if.consumer src,
  output logic     txd
);

  import uart_pkg::*;

  localparam int unsigned CNT_W = `UART_CNT_W;
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(`UART_CLKS_PER_BIT - 1);

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

  tx_state_e        state;
  logic [CNT_W-1:0] bit_cnt;
  logic [2:0]       bit_idx;
  uart_byte_t       tx_byte;
  logic             bit_done;

  // take the byte as soon as the engine is free
  assign src.rd_en = (state == TX_IDLE) && src.rd_valid;
  assign bit_done  = (bit_cnt == '0);

  // local copy frees the holding register right away
  always_ff @(posedge clk) begin
    if (src.rd_en) begin
      tx_byte <= src.rd_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= TX_IDLE;
      bit_cnt <= '0;
      bit_idx <= '0;
      txd     <= 1'b1;
    end else begin
      // one bit time per state step, bit_cnt reloads at every bit edge
      if (!bit_done) begin
        bit_cnt <= bit_cnt - 1'b1;
      end
      case (state)
        TX_IDLE: begin
          if (src.rd_en) begin
            // start bit begins on this edge
            txd     <= 1'b0;
            bit_cnt <= BIT_LAST;
            state   <= TX_START;
          end
        end
        TX_START: begin
          if (bit_done) begin
            txd     <= tx_byte[0];
            bit_idx <= '0;
            bit_cnt <= BIT_LAST;
            state   <= TX_DATA;
          end
        end
        TX_DATA: begin
          if (bit_done) begin
            bit_cnt <= BIT_LAST;
            if (bit_idx == 3'd7) begin
              // last data bit done, stop bit is a high level
              txd   <= 1'b1;
              state <= TX_STOP;
            end else begin
              txd     <= tx_byte[bit_idx + 3'd1];
              bit_idx <= bit_idx + 3'd1;
            end
          end
        end
        default: begin
          // stop bit, txd already high and stays there in idle
          if (bit_done) begin
            state <= TX_IDLE;
          end
        end
      endcase
    end
  end

endmodule

/* verilog/uart_rx.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uart receive engine
// synchronizes rxd, samples 8N1 frames at mid-bit and stores
// each byte with its frame-error flag in the rx holding register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "uart_macros.svh"

module uart_rx (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     rxd,
  hold_if.producer dst
);

  import uart_pkg::*;

  localparam int unsigned CNT_W = `UART_CNT_W;
  localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(`UART_CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(`UART_CLKS_PER_BIT / 2 - 1);

  typedef enum logic [1:0] {RX_HUNT, RX_START, RX_DATA, RX_STOP} rx_state_e;

  rx_state_e        state;
  logic             rxd_meta;
  logic             rxd_sync;
  logic             rxd_prev;
  logic             start_edge;
  logic [CNT_W-1:0] bit_cnt;
  logic [2:0]       bit_idx;
  uart_byte_t       rx_shift;
  logic             bit_done;
  uart_rx_frame_t   frame;

  // two-flop synchronizer plus one more stage for edge detect
  // idle line is high, so reset to high
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      rxd_prev <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      rxd_prev <= rxd_sync;
    end
  end

  assign start_edge = rxd_prev && !rxd_sync;
  assign bit_done   = (bit_cnt == '0);

  // data bits arrive LSB first, shift in from the top
  always_ff @(posedge clk) begin
    if (state == RX_DATA && bit_done) begin
      rx_shift <= {rxd_sync, rx_shift[7:1]};
    end
  end

  // completed frame, stop sample taken in the same cycle as the write
  assign frame.data      = rx_shift;
  assign frame.frame_err = !rxd_sync;

  // frame dropped when the CPU has not yet read the last one
  assign dst.wr_en   = (state == RX_STOP) && bit_done && !dst.full;
  assign dst.wr_data = frame;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= RX_HUNT;
      bit_cnt <= '0;
      bit_idx <= '0;
    end else begin
      if (!bit_done) begin
        bit_cnt <= bit_cnt - 1'b1;
      end
      case (state)
        RX_HUNT: begin
          if (start_edge) begin
            // wait to the middle of the start bit
            bit_cnt <= HALF_LAST;
            state   <= RX_START;
          end
        end
        RX_START: begin
          if (bit_done) begin
            // a high line at mid start bit was only a glitch
            if (!rxd_sync) begin
              bit_cnt <= BIT_LAST;
              bit_idx <= '0;
              state   <= RX_DATA;
            end else begin
              state <= RX_HUNT;
            end
          end
        end
        RX_DATA: begin
          if (bit_done) begin
            bit_cnt <= BIT_LAST;
            bit_idx <= bit_idx + 3'd1;
            if (bit_idx == 3'd7) begin
              state <= RX_STOP;
            end
          end
        end
        default: begin
          // mid stop bit, frame written and back to hunting
          if (bit_done) begin
            state <= RX_HUNT;
          end
        end
      endcase
    end
  end

endmodule

/* verilog/uart_apb_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB uart peripheral
// register decode, two one-entry holding registers and the
// tx and rx serial engines
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module uart_apb_top (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [3:0]  paddr,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  output logic        txd,
  input  logic        rxd
);

  import uart_pkg::*;

  // decode -> tx engine, one byte deep
  hold_if #(.payload_t(uart_byte_t)) tx_link ();
  // rx engine -> decode, byte plus frame error
  hold_if #(.payload_t(uart_rx_frame_t)) rx_link ();

  apb_reg_decode u_decode (
    .clk     (clk),
    .rst_n   (rst_n),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .tx      (tx_link),
    .rx      (rx_link)
  );

  uart_hold_reg #(.payload_t(uart_byte_t)) u_tx_hold (.clk(clk), .rst_n(rst_n), .link(tx_link));

  uart_hold_reg #(.payload_t(uart_rx_frame_t)) u_rx_hold (
    .clk   (clk),
    .rst_n (rst_n),
    .link  (rx_link)
  );

  uart_tx u_tx (.clk(clk), .rst_n(rst_n), .src(tx_link), .txd(txd));

  uart_rx u_rx (.clk(clk), .rst_n(rst_n), .rxd(rxd), .dst(rx_link));

endmodule

/* bench/uart_clk_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock and reset
// free-running clock, rst_n held low for a few cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module uart_clk_gen #(
  parameter int PERIOD     = 8,
  parameter int RST_CYCLES = 3
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // release on a rising edge, reset is synchronous
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

/* bench/uart_apb_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uart APB peripheral testbench
// directed tests over the APB registers and the serial pins
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "uart_macros.svh"

module uart_apb_tb;

  import uart_pkg::*;

  localparam int CPB          = `UART_CLKS_PER_BIT;
  localparam int FRAME_CYCLES = 10 * CPB;
  // about eight frames are exchanged in total
  localparam int TIMEOUT      = 20 * FRAME_CYCLES + 200;

  logic        clk;
  logic        rst_n;
  logic [3:0]  paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        txd;
  logic        rxd;

  integer seed      = 61;
  int     err_cnt   = 0;
  int     pass_cnt  = 0;
  int     fail_cnt  = 0;
  int     cycle_cnt = 0;

  uart_clk_gen #(.PERIOD(8), .RST_CYCLES(3)) u_clk_gen (.clk(clk), .rst_n(rst_n));

  uart_apb_top uut (
    .clk     (clk),
    .rst_n   (rst_n),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .txd     (txd),
    .rxd     (rxd)
  );

  task automatic check_byte(input string name, input uart_byte_t exp, input uart_byte_t act);
    if (act !== exp) begin
      $display("[ERROR] %s expected 0x%02h got 0x%02h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_status(input uart_status_t exp, input uart_status_t act);
    if (act !== exp) begin
      $display("[ERROR] status expected 0x%0h got 0x%0h", exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_err(input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] pslverr expected 0x%0h got 0x%0h", exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %s expected 0x%0h got 0x%0h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s expected 0x%08h got 0x%08h", name, exp, act);
      err_cnt++;
    end
  endtask

  // setup phase, access phase, then idle on the edge ending the access
  task automatic apb_xfer(input logic [3:0] addr, input logic wr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    @(posedge clk);
    paddr   <= addr;
    pwrite  <= wr;
    pwdata  <= wdata;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge clk);
    penable <= 1'b1;
    // responses are combinational, stable by the falling edge
    @(negedge clk);
    rdata = prdata;
    err   = pslverr;
    check_bit("pready", 1'b1, pready);
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused;
    apb_xfer(addr, 1'b1, data, unused, err);
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
    apb_xfer(addr, 1'b0, 32'h0, data, err);
    // bits above the status word or the data byte read as zero
    if (addr == REG_STATUS) begin
      check_word("prdata[31:3]", 32'h0, data >> 3);
    end else begin
      check_word("prdata[31:8]", 32'h0, data >> 8);
    end
  endtask

  // 8N1 frame on rxd, stop level selectable to force a frame error
  task automatic serial_send(input uart_byte_t data, input logic stop_val);
    @(posedge clk);
    rxd <= 1'b0;
    repeat (CPB) @(posedge clk);
    for (int i = 0; i < 8; i++) begin
      rxd <= data[i];
      repeat (CPB) @(posedge clk);
    end
    rxd <= stop_val;
    repeat (CPB) @(posedge clk);
    rxd <= 1'b1;
  endtask

  task automatic serial_capture(output uart_byte_t data, output logic start_bit,
                                output logic stop_bit);
    @(negedge txd);
    // half a bit to the middle of the start bit
    repeat (CPB / 2) @(negedge clk);
    start_bit = txd;
    for (int i = 0; i < 8; i++) begin
      repeat (CPB) @(negedge clk);
      data[i] = txd;
    end
    repeat (CPB) @(negedge clk);
    stop_bit = txd;
  endtask

  // captures one frame and runs on to the end of its stop bit
  task automatic expect_frame(input uart_byte_t exp);
    uart_byte_t data;
    logic       start_bit;
    logic       stop_bit;
    serial_capture(data, start_bit, stop_bit);
    check_bit("txd start bit", 1'b0, start_bit);
    check_byte("txd data", exp, data);
    check_bit("txd stop bit", 1'b1, stop_bit);
    repeat (CPB / 2 + 1) @(negedge clk);
  endtask

  task automatic wait_rx_avail(output uart_status_t st);
    logic [31:0] rdata;
    logic        err;
    int          polls;
    polls = 0;
    do begin
      apb_read(REG_STATUS, rdata, err);
      polls++;
    end while (!rdata[1] && polls < 16);
    st = rdata[$bits(uart_status_t)-1:0];
    if (!st.rx_avail) begin
      $display("rx_avail never came up after a frame was sent on rxd");
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      pass_cnt++;
      $display("test %s: ok", name);
    end else begin
      fail_cnt++;
      $display("test %s: %0d errors", name, err_cnt - errs_before);
    end
  endtask

  task automatic reset_state();
    logic [31:0] rdata;
    logic        err;
    int          errs;
    errs = err_cnt;
    @(negedge clk);
    check_bit("txd", 1'b1, txd);
    check_err(1'b0, pslverr);
    apb_read(REG_STATUS, rdata, err);
    check_status('0, rdata[2:0]);
    check_err(1'b0, err);
    report_test("reset state", errs);
  endtask

  task automatic tx_single_byte();
    uart_byte_t  b;
    logic [31:0] rdata;
    logic        err;
    int          errs;
    errs = err_cnt;
    b = uart_byte_t'($random(seed));
    apb_write(REG_DATA, {24'h0, b}, err);
    check_err(1'b0, err);
    expect_frame(b);
    apb_read(REG_STATUS, rdata, err);
    check_status('0, rdata[2:0]);
    report_test("tx single byte", errs);
  endtask

  // second byte waits in the holding register, third is refused
  task automatic tx_back_to_back();
    uart_byte_t b0;
    uart_byte_t b1;
    logic       e0;
    logic       e1;
    logic       e2;
    int         errs;
    errs = err_cnt;
    b0 = uart_byte_t'($random(seed));
    b1 = uart_byte_t'($random(seed));
    fork
      begin
        apb_write(REG_DATA, {24'h0, b0}, e0);
        apb_write(REG_DATA, {24'h0, b1}, e1);
        apb_write(REG_DATA, 32'h0000_00a5, e2);
      end
      begin
        expect_frame(b0);
        expect_frame(b1);
      end
    join
    check_err(1'b0, e0);
    check_err(1'b0, e1);
    check_err(1'b1, e2);
    report_test("tx back to back", errs);
  endtask

  task automatic rx_three_frames();
    uart_byte_t   b;
    uart_status_t st;
    uart_status_t exp_st;
    logic [31:0]  rdata;
    logic         err;
    int           errs;
    errs = err_cnt;
    exp_st = '0;
    exp_st.rx_avail = 1'b1;
    for (int i = 0; i < 3; i++) begin
      b = uart_byte_t'($random(seed));
      serial_send(b, 1'b1);
      wait_rx_avail(st);
      check_status(exp_st, st);
      apb_read(REG_DATA, rdata, err);
      check_byte("prdata", b, rdata[7:0]);
      check_err(1'b0, err);
    end
    report_test("rx three frames", errs);
  endtask

  task automatic rx_frame_error();
    uart_byte_t   b;
    uart_status_t st;
    uart_status_t exp_st;
    logic [31:0]  rdata;
    logic         err;
    int           errs;
    errs = err_cnt;
    exp_st = '0;
    exp_st.rx_avail     = 1'b1;
    exp_st.rx_frame_err = 1'b1;
    b = uart_byte_t'($random(seed));
    serial_send(b, 1'b0);
    wait_rx_avail(st);
    check_status(exp_st, st);
    apb_read(REG_DATA, rdata, err);
    check_byte("prdata", b, rdata[7:0]);
    check_err(1'b0, err);
    // register now empty
    apb_read(REG_DATA, rdata, err);
    check_byte("prdata", 8'h00, rdata[7:0]);
    check_err(1'b1, err);
    report_test("rx frame error", errs);
  endtask

  task automatic unmapped_offsets();
    uart_byte_t   b;
    uart_status_t st;
    uart_status_t exp_st;
    logic [3:0]   addr;
    logic [31:0]  rdata;
    logic         err;
    int           errs;
    errs = err_cnt;
    // park a received frame so a stray pop would show in STATUS
    b = uart_byte_t'($random(seed));
    serial_send(b, 1'b1);
    wait_rx_avail(st);
    exp_st = '0;
    exp_st.rx_avail = 1'b1;
    for (int i = 0; i < 2; i++) begin
      addr = (i == 0) ? 4'h8 : 4'hc;
      apb_write(addr, 32'h0000_005a, err);
      check_err(1'b1, err);
      apb_read(addr, rdata, err);
      check_err(1'b1, err);
      check_byte("prdata", 8'h00, rdata[7:0]);
      // a stray push would have started a frame by now
      @(negedge clk);
      check_bit("txd", 1'b1, txd);
    end
    apb_read(REG_STATUS, rdata, err);
    check_status(exp_st, rdata[2:0]);
    check_err(1'b0, err);
    // parked frame still intact
    apb_read(REG_DATA, rdata, err);
    check_byte("prdata", b, rdata[7:0]);
    check_err(1'b0, err);
    report_test("unmapped offsets", errs);
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT) begin
      $display("timeout after %0d cycles, a test kept waiting on the DUT", cycle_cnt);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  initial begin
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    rxd     = 1'b1;
    wait (rst_n === 1'b1);
    @(posedge clk);
    reset_state();
    tx_single_byte();
    tx_back_to_back();
    rx_three_frames();
    rx_frame_error();
    unmapped_offsets();
    $display("tests passed %0d failed %0d, %0d errors", pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+include
verilog/uart_pkg.sv
verilog/hold_if.sv
verilog/uart_hold_reg.sv
verilog/apb_reg_decode.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_apb_top.sv
bench/uart_clk_gen.sv
bench/uart_apb_tb.sv
